//--- Makefile
# Verilator build and run for the load/store front end testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ramio
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
src/ramio_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/word_ram.sv
src/load_store_unit.sv
src/io_regs.sv
src/ramio.sv
tb/tb_clock_gen.sv
tb/tb_ramio.sv

//--- src/io_regs.sv
//----------------------------------------------------------------------------
// I/O register file at the top of the map: LED nibble, UART transmit and
// receive holding words. runs the go handshakes towards both UARTs
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module io_regs
  import ramio_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic [2:0]        read_type,
  input  logic [1:0]        write_type,
  input  logic [ADDR_W-1:0] address,
  input  logic [DATA_W-1:0] data_in,
  input  logic              tx_busy,
  input  logic [7:0]        rx_data,
  input  logic              rx_data_ready,
  output logic              io_hit,
  output logic [DATA_W-1:0] io_rdata,
  output logic [3:0]        led,
  output logic              tx_go,
  output logic [7:0]        tx_data,
  output logic              rx_go
);

  logic              hit_led;
  logic              hit_out;
  logic              hit_in;
  logic              io_rd;
  logic              io_wr;
  logic [DATA_W-1:0] tx_word;
  logic [DATA_W-1:0] rx_word;

  // the only address compare in the design
  assign hit_led = address == ADDR_LED;
  assign hit_out = address == ADDR_UART_OUT;
  assign hit_in  = address == ADDR_UART_IN;
  assign io_hit  = hit_led || hit_out || hit_in;

  // register side effects need an enabled request
  assign io_rd = enable && (read_type[1:0] != SIZE_NONE);
  assign io_wr = enable && (write_type != SIZE_NONE);

  always_comb begin
    io_rdata = '0;
    if (hit_out) io_rdata = tx_word;
    if (hit_in) io_rdata = rx_word;
    if (hit_led) io_rdata = {{(DATA_W-4){1'b0}}, led};
  end

  // transmitter latches the byte when it starts the frame
  assign tx_data = tx_word[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led     <= 4'b1111;
      tx_word <= IO_IDLE;
      tx_go   <= 1'b0;
      rx_word <= IO_IDLE;
      rx_go   <= 1'b1;
    end else begin
      // reading the receive word consumes it
      if (io_rd && hit_in) begin
        rx_word <= IO_IDLE;
      end else if (rx_go && rx_data_ready) begin
        // copy and ack; an unread byte is overwritten
        rx_word <= {{(DATA_W-8){1'b0}}, rx_data};
        rx_go   <= 1'b0;
      end
      // ack lasts one cycle, then re-arm
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // frame done, release go and show idle
      if (tx_go && !tx_busy) begin
        tx_go   <= 1'b0;
        tx_word <= IO_IDLE;
      end
      if (io_wr && hit_out) begin
        tx_word <= {{(DATA_W-8){1'b0}}, data_in[7:0]};
        tx_go   <= 1'b1;
      end

      if (io_wr && hit_led) begin
        led <= data_in[3:0];
      end
    end
  end

endmodule

//--- src/load_store_unit.sv
//----------------------------------------------------------------------------
// combinational load/store datapath. steers store data onto RAM byte lanes,
// extracts and extends loads, and picks RAM or I/O read data for the client
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module load_store_unit
  import ramio_pkg::*;
(
  input  logic                     enable,
  input  logic [2:0]               read_type,
  input  logic [1:0]               write_type,
  input  logic [ADDR_W-1:0]        address,
  input  logic [DATA_W-1:0]        data_in,
  input  logic                     io_hit,
  input  logic [DATA_W-1:0]        io_rdata,
  input  logic [DATA_W-1:0]        ram_rdata,
  input  logic                     ram_rvalid,
  output logic                     ram_en,
  output logic [RAM_WORD_BITS-1:0] ram_word_addr,
  output logic [3:0]               ram_wstrb,
  output logic [DATA_W-1:0]        ram_wdata,
  output logic [DATA_W-1:0]        data_out,
  output logic                     data_out_ready
);

  logic              is_read;
  logic              is_write;
  logic              ld_signed;
  logic [7:0]        ld_byte;
  logic [15:0]       ld_half;
  logic [DATA_W-1:0] load_data;

  assign is_read   = read_type[1:0] != SIZE_NONE;
  assign is_write  = write_type != SIZE_NONE;
  assign ld_signed = read_type[LOAD_SIGNED_BIT];

  // RAM sees only non-I/O accesses, higher address bits fold onto the array
  assign ram_en        = enable && !io_hit && (is_read || is_write);
  assign ram_word_addr = address[RAM_WORD_BITS+1:2];

  //--------------------------------------------------------------------------
  // store lane steering
  //--------------------------------------------------------------------------
  always_comb begin
    ram_wstrb = 4'b0000;
    ram_wdata = '0;
    if (enable && !io_hit) begin
      case (write_type)
        SIZE_BYTE: begin
          // byte copied to every lane, the strobe picks one
          ram_wdata = {4{data_in[7:0]}};
          ram_wstrb = 4'b0001 << address[1:0];
        end
        SIZE_HALF: begin
          ram_wdata = {2{data_in[15:0]}};
          // odd address writes nothing
          if (!address[0]) begin
            ram_wstrb = address[1] ? 4'b1100 : 4'b0011;
          end
        end
        SIZE_WORD: begin
          ram_wdata = data_in;
          ram_wstrb = 4'b1111;
        end
        default: ;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // load extraction and extension
  //--------------------------------------------------------------------------
  assign ld_byte = ram_rdata[{address[1:0], 3'b000} +: 8];
  assign ld_half = address[1] ? ram_rdata[31:16] : ram_rdata[15:0];

  always_comb begin
    load_data = '0;
    case (read_type[1:0])
      SIZE_BYTE: load_data = {{(DATA_W-8){ld_signed & ld_byte[7]}}, ld_byte};
      SIZE_HALF: begin
        // misaligned half word reads as zero
        if (!address[0]) begin
          load_data = {{(DATA_W-16){ld_signed & ld_half[15]}}, ld_half};
        end
      end
      SIZE_WORD: load_data = ram_rdata;
      default: ;
    endcase
  end

  // I/O answers from the register file, everything else from RAM
  assign data_out = io_hit ? io_rdata : load_data;

  // I/O and stores finish at once; RAM loads wait for the registered word
  always_comb begin
    data_out_ready = 1'b0;
    if (enable) begin
      if (io_hit || is_write) begin
        data_out_ready = 1'b1;
      end else if (is_read) begin
        data_out_ready = ram_rvalid;
      end
    end
  end

endmodule

//--- src/ramio.sv
//----------------------------------------------------------------------------
// load/store front end top level. a client issues byte, half word and word
// accesses; RAM sits low in the map, LEDs and UART registers at the top.
// only wiring lives here
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module ramio
  import ramio_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic [2:0]        read_type,
  input  logic [1:0]        write_type,
  input  logic [ADDR_W-1:0] address,
  input  logic [DATA_W-1:0] data_in,
  output logic [DATA_W-1:0] data_out,
  output logic              data_out_ready,
  output logic [3:0]        led,
  output logic              uart_tx,
  input  logic              uart_rx
);

  // io decode towards the load/store unit
  logic                     io_hit;
  logic [DATA_W-1:0]        io_rdata;

  // RAM port
  logic                     ram_en;
  logic [RAM_WORD_BITS-1:0] ram_word_addr;
  logic [3:0]               ram_wstrb;
  logic [DATA_W-1:0]        ram_wdata;
  logic [DATA_W-1:0]        ram_rdata;
  logic                     ram_rvalid;

  // uart handshakes
  logic                     tx_go;
  logic [7:0]               tx_data;
  logic                     tx_busy;
  logic                     rx_go;
  logic [7:0]               rx_data;
  logic                     rx_data_ready;

  load_store_unit u_lsu (
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .io_hit         (io_hit),
    .io_rdata       (io_rdata),
    .ram_rdata      (ram_rdata),
    .ram_rvalid     (ram_rvalid),
    .ram_en         (ram_en),
    .ram_word_addr  (ram_word_addr),
    .ram_wstrb      (ram_wstrb),
    .ram_wdata      (ram_wdata),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

  word_ram u_ram (
    .clk           (clk),
    .rst_n         (rst_n),
    .ram_en        (ram_en),
    .ram_word_addr (ram_word_addr),
    .ram_wstrb     (ram_wstrb),
    .ram_wdata     (ram_wdata),
    .ram_rdata     (ram_rdata),
    .ram_rvalid    (ram_rvalid)
  );

  io_regs u_io (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .read_type     (read_type),
    .write_type    (write_type),
    .address       (address),
    .data_in       (data_in),
    .tx_busy       (tx_busy),
    .rx_data       (rx_data),
    .rx_data_ready (rx_data_ready),
    .io_hit        (io_hit),
    .io_rdata      (io_rdata),
    .led           (led),
    .tx_go         (tx_go),
    .tx_data       (tx_data),
    .rx_go         (rx_go)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_go   (tx_go),
    .tx_data (tx_data),
    .uart_tx (uart_tx),
    .tx_busy (tx_busy)
  );

  uart_rx u_uart_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .uart_rx       (uart_rx),
    .rx_go         (rx_go),
    .rx_data       (rx_data),
    .rx_data_ready (rx_data_ready)
  );

endmodule

//--- src/ramio_pkg.sv
//----------------------------------------------------------------------------
// shared constants for the load/store front end: bus widths, the I/O map,
// access-size codes and UART timing. imported by every RTL module
//----------------------------------------------------------------------------

package ramio_pkg;

  // client bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // on-chip RAM, address bits 11:2 pick the word
  localparam int RAM_WORD_BITS = 10;
  localparam int RAM_WORDS     = 1 << RAM_WORD_BITS;

  //--------------------------------------------------------------------------
  // I/O map at the top of the address space
  //--------------------------------------------------------------------------
  // low nibble only, 0 = led on
  localparam logic [ADDR_W-1:0] ADDR_LED      = 32'hffff_fffc;
  localparam logic [ADDR_W-1:0] ADDR_UART_OUT = 32'hffff_fff8;
  localparam logic [ADDR_W-1:0] ADDR_UART_IN  = 32'hffff_fff4;

  // value seen in an idle uart holding register
  localparam logic [DATA_W-1:0] IO_IDLE = '1;

  // access sizes, low bits of read_type and all of write_type
  localparam logic [1:0] SIZE_NONE = 2'b00;
  localparam logic [1:0] SIZE_BYTE = 2'b01;
  localparam logic [1:0] SIZE_HALF = 2'b10;
  localparam logic [1:0] SIZE_WORD = 2'b11;

  // read_type bit that asks for sign extension
  localparam int LOAD_SIGNED_BIT = 2;

  //--------------------------------------------------------------------------
  // UART
  //--------------------------------------------------------------------------
  localparam int CLKS_PER_BIT = 16;
  localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

  // frame FSM states, shared by transmitter and receiver
  localparam logic [2:0] UART_IDLE  = 3'd0;
  localparam logic [2:0] UART_START = 3'd1;
  localparam logic [2:0] UART_DATA  = 3'd2;
  localparam logic [2:0] UART_STOP  = 3'd3;
  localparam logic [2:0] UART_DONE  = 3'd4;

endpackage

//--- src/uart_rx.sv
//----------------------------------------------------------------------------
// 8N1 UART receiver. armed while rx_go is high; rx_data_ready holds with
// rx_data until the owner drops rx_go to acknowledge
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module uart_rx
  import ramio_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       uart_rx,
  input  logic       rx_go,
  output logic [7:0] rx_data,
  output logic       rx_data_ready
);

  logic [2:0]           state;
  logic [CLK_CNT_W-1:0] cnt;
  logic [2:0]           bit_idx;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 bit_end;
  logic                 half_end;

  assign bit_end  = cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);
  assign half_end = cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);

  assign rx_data_ready = state == UART_DONE;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= uart_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= UART_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          cnt <= '0;
          if (rx_go && !rx_sync) state <= UART_START;
        end
        UART_START: begin
          // recheck low at mid start bit, a glitch goes back to idle
          if (half_end) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? UART_IDLE : UART_DATA;
          end
        end
        UART_DATA: begin
          // one full bit on, so each sample lands mid-bit
          if (bit_end) begin
            rx_data <= {rx_sync, rx_data[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= UART_STOP;
          end
        end
        UART_STOP: begin
          // framing error drops the byte
          if (bit_end) state <= rx_sync ? UART_DONE : UART_IDLE;
        end
        default: begin
          if (!rx_go) state <= UART_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/uart_tx.sv
//----------------------------------------------------------------------------
// 8N1 UART transmitter. raise tx_go to send tx_data, wait for tx_busy to
// fall, then drop tx_go before the next frame
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module uart_tx
  import ramio_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_go,
  input  logic [7:0] tx_data,
  output logic       uart_tx,
  output logic       tx_busy
);

  logic [2:0]           state;
  logic [CLK_CNT_W-1:0] cnt;
  logic [2:0]           bit_idx;
  logic [7:0]           shreg;
  logic                 bit_end;

  assign bit_end = cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);

  // busy already in the go cycle, so the owner does not see a gap
  assign tx_busy = (state == UART_IDLE) ? tx_go : (state != UART_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= UART_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      uart_tx <= 1'b1;
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          cnt     <= '0;
          uart_tx <= 1'b1;
          if (tx_go) begin
            // start bit goes out right away
            shreg   <= tx_data;
            uart_tx <= 1'b0;
            state   <= UART_START;
          end
        end
        UART_START: begin
          if (bit_end) begin
            uart_tx <= shreg[0];
            bit_idx <= '0;
            state   <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            // lsb first
            shreg <= shreg >> 1;
            if (bit_idx == 3'd7) begin
              uart_tx <= 1'b1;
              state   <= UART_STOP;
            end else begin
              uart_tx <= shreg[1];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        UART_STOP: begin
          if (bit_end) state <= UART_DONE;
        end
        default: begin
          // hold until the owner acks by dropping go
          if (!tx_go) state <= UART_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/word_ram.sv
//----------------------------------------------------------------------------
// single-port word RAM with byte write lanes and a registered read. the
// valid flag says the held word still matches the current read request
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module word_ram
  import ramio_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ram_en,
  input  logic [RAM_WORD_BITS-1:0] ram_word_addr,
  input  logic [3:0]               ram_wstrb,
  input  logic [DATA_W-1:0]        ram_wdata,
  output logic [DATA_W-1:0]        ram_rdata,
  output logic                     ram_rvalid
);

  logic [DATA_W-1:0]        mem [RAM_WORDS];
  logic [RAM_WORD_BITS-1:0] rd_addr_q;
  logic                     rd_hold_q;
  logic                     is_write;

  // any strobe makes it a write, otherwise an enabled access is a read
  assign is_write = |ram_wstrb;

  // array and read port
  always_ff @(posedge clk) begin
    if (ram_en && is_write) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_wstrb[i]) begin
          mem[ram_word_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
        end
      end
    end
    if (ram_en && !is_write) begin
      ram_rdata <= mem[ram_word_addr];
      rd_addr_q <= ram_word_addr;
    end
  end

  // set after each read cycle, cleared by a write or an idle cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_hold_q <= 1'b0;
    end else begin
      rd_hold_q <= ram_en && !is_write;
    end
  end

  // word is usable only while the same read stays on the port
  assign ram_rvalid = rd_hold_q && ram_en && !is_write && (ram_word_addr == rd_addr_q);

endmodule

//--- tb/tb_clock_gen.sv
//----------------------------------------------------------------------------
// testbench clock and reset. 100 ns clock period, rst_n held low over the
// first five rising edges and then released on an edge
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // synchronous reset held low for five edges
  initial begin
    rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- tb/tb_ramio.sv
//----------------------------------------------------------------------------
// testbench for the load/store front end. drives client requests, keeps a
// byte image of RAM as reference, drives and decodes both UART lines.
// run through files.f, top module tb_ramio
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_ramio
  import ramio_pkg::*;
();

  localparam int MAX_CYCLES = 20000;
  localparam int N_STORES   = 200;
  localparam int N_LED      = 8;

  logic              clk;
  logic              rst_n;
  logic              enable;
  logic [2:0]        read_type;
  logic [1:0]        write_type;
  logic [ADDR_W-1:0] address;
  logic [DATA_W-1:0] data_in;
  logic [DATA_W-1:0] data_out;
  logic              data_out_ready;
  logic [3:0]        led;
  logic              uart_tx;
  logic              uart_rx;

  integer seed;
  int     cycles       = 0;
  int     checks       = 0;
  int     value_errors = 0;
  int     line_errors  = 0;

  // byte image of the low 4 KB of RAM
  logic [7:0] shadow [4096];
  // bytes decoded from uart_tx
  logic [7:0] tx_frames [$];

  // checks waiting for the comparing process
  string             chk_name [$];
  logic [DATA_W-1:0] chk_exp [$];
  logic [DATA_W-1:0] chk_act [$];
  time               chk_time [$];

  tb_clock_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ramio u_ramio (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (uart_tx),
    .uart_rx        (uart_rx)
  );

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------
  // expected load result from the byte image
  function automatic logic [DATA_W-1:0] ref_load(input logic [2:0]  rtype,
                                                 input logic [11:0] addr);
    logic [11:0] base;
    logic [7:0]  b;
    logic [15:0] h;
    logic        sgn;
    base = {addr[11:2], 2'b00};
    sgn  = rtype[LOAD_SIGNED_BIT];
    b    = shadow[addr];
    h    = {shadow[addr + 12'd1], shadow[addr]};
    ref_load = '0;
    case (rtype[1:0])
      SIZE_BYTE: ref_load = {{24{sgn & b[7]}}, b};
      SIZE_HALF: begin
        // odd address gives zero
        if (!addr[0]) begin
          ref_load = {{16{sgn & h[15]}}, h};
        end
      end
      SIZE_WORD: begin
        ref_load = {shadow[base + 12'd3], shadow[base + 12'd2],
                    shadow[base + 12'd1], shadow[base]};
      end
      default: ;
    endcase
  endfunction

  // store rules applied to the byte image
  task automatic update_shadow(input logic [1:0] wsize, input logic [11:0] addr,
                               input logic [DATA_W-1:0] d);
    logic [11:0] base;
    base = {addr[11:2], 2'b00};
    case (wsize)
      SIZE_BYTE: shadow[addr] = d[7:0];
      SIZE_HALF: begin
        // misaligned half word is dropped
        if (!addr[0]) begin
          shadow[addr]         = d[7:0];
          shadow[addr + 12'd1] = d[15:8];
        end
      end
      SIZE_WORD: begin
        for (int i = 0; i < 4; i++) begin
          shadow[base + 12'(i)] = d[8*i +: 8];
        end
      end
      default: ;
    endcase
  endtask

  //--------------------------------------------------------------------------
  // bus and line tasks
  //--------------------------------------------------------------------------
  // request is held after return, until the next one replaces it
  task automatic bus_access(input logic [2:0] rtype, input logic [1:0] wsize,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata);
    @(posedge clk);
    enable     <= 1'b1;
    read_type  <= rtype;
    write_type <= wsize;
    address    <= addr;
    data_in    <= wdata;
    @(negedge clk);
    while (!data_out_ready) @(negedge clk);
    rdata = data_out;
  endtask

  task automatic read_access(input logic [2:0] rtype, input logic [ADDR_W-1:0] addr,
                             output logic [DATA_W-1:0] rdata);
    bus_access(rtype, SIZE_NONE, addr, '0, rdata);
  endtask

  task automatic write_access(input logic [1:0] wsize, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] unused;
    bus_access(3'b000, wsize, addr, wdata, unused);
  endtask

  // a held write lands on this edge as the request drops
  task automatic idle_bus();
    @(posedge clk);
    enable     <= 1'b0;
    read_type  <= 3'b000;
    write_type <= SIZE_NONE;
  endtask

  task automatic ram_store(input logic [1:0] wsize, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata);
    write_access(wsize, addr, wdata);
    update_shadow(wsize, addr[11:0], wdata);
  endtask

  task automatic expect_value(input string name, input logic [DATA_W-1:0] exp_v,
                              input logic [DATA_W-1:0] act_v);
    chk_name.push_back(name);
    chk_exp.push_back(exp_v);
    chk_act.push_back(act_v);
    chk_time.push_back($time);
  endtask

  task automatic ram_load_check(input logic [2:0] rtype, input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] got;
    read_access(rtype, addr, got);
    expect_value("data_out", ref_load(rtype, addr[11:0]), got);
  endtask

  // 8N1 frame on uart_rx with the lsb first
  task automatic send_serial(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, value errors %0d, line errors %0d",
             checks, value_errors, line_errors);
  endtask

  //--------------------------------------------------------------------------
  // monitor, comparator, timeout
  //--------------------------------------------------------------------------
  // samples each bit near its middle, counted on falling clock edges
  always begin : decode_tx_line
    logic [7:0] frame_byte;
    @(negedge uart_tx);
    if (rst_n === 1'b1) begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        line_errors++;
        $display("start bit on uart_tx ended early at %0d ns", $time);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        frame_byte[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        line_errors++;
        $display("no stop bit on uart_tx at %0d ns", $time);
      end
      tx_frames.push_back(frame_byte);
    end
  end

  always @(posedge clk) begin : compare_results
    string             name;
    logic [DATA_W-1:0] exp_v;
    logic [DATA_W-1:0] act_v;
    time               at;
    while (chk_act.size() > 0) begin
      name  = chk_name.pop_front();
      exp_v = chk_exp.pop_front();
      act_v = chk_act.pop_front();
      at    = chk_time.pop_front();
      checks++;
      if (act_v !== exp_v) begin
        value_errors++;
        $display("error at %0d ns: %s expected %h, got %h", at, name, exp_v, act_v);
      end
    end
  end

  // whole run is about 3600 cycles
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run still going after %0d cycles", MAX_CYCLES);
      report_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------
  initial begin : run_tests
    logic [DATA_W-1:0] rnd;
    logic [DATA_W-1:0] got;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [1:0]        wsize;
    logic [2:0]        rtype;
    logic [9:0]        widx;
    logic [7:0]        byte_val;

    seed = 32'h2a7f;
    enable     <= 1'b0;
    read_type  <= 3'b000;
    write_type <= SIZE_NONE;
    address    <= '0;
    data_in    <= '0;
    uart_rx    <= 1'b1;

    wait (rst_n === 1'b1);
    @(negedge clk);

    // reset state
    expect_value("led", 32'hf, {28'b0, led});
    expect_value("uart_tx", 32'h1, {31'b0, uart_tx});
    read_access({1'b0, SIZE_WORD}, ADDR_UART_OUT, got);
    expect_value("data_out uart out", IO_IDLE, got);
    read_access({1'b0, SIZE_WORD}, ADDR_UART_IN, got);
    expect_value("data_out uart in", IO_IDLE, got);

    // fill every word with a pattern built from the word index
    for (int w = 0; w < RAM_WORDS; w++) begin
      widx  = w[9:0];
      addr  = {20'b0, widx, 2'b00};
      wdata = {widx, ~widx, widx, 2'b10};
      ram_store(SIZE_WORD, addr, wdata);
    end

    // random stores each followed by loads of every size
    for (int n = 0; n < N_STORES; n++) begin
      rnd   = $random(seed);
      wsize = (rnd[1:0] == SIZE_NONE) ? SIZE_HALF : rnd[1:0];
      addr  = {20'b0, rnd[13:2]};
      wdata = $random(seed);
      ram_store(wsize, addr, wdata);
      for (int s = 1; s < 4; s++) begin
        rnd   = $random(seed);
        rtype = {rnd[0], s[1:0]};
        ram_load_check(rtype, addr);
      end
      // and one load somewhere else
      rnd   = $random(seed);
      rtype = {rnd[2], (rnd[1:0] == SIZE_NONE) ? SIZE_WORD : rnd[1:0]};
      ram_load_check(rtype, {20'b0, rnd[15:4]});
    end

    // LEDs follow writes while RAM writes leave them alone
    for (int k = 0; k < N_LED; k++) begin
      rnd = $random(seed);
      write_access(SIZE_WORD, ADDR_LED, rnd);
      idle_bus();
      @(negedge clk);
      expect_value("led", {28'b0, rnd[3:0]}, {28'b0, led});
      ram_store(SIZE_WORD, {20'b0, rnd[15:4]}, ~rnd);
      idle_bus();
      @(negedge clk);
      expect_value("led", {28'b0, rnd[3:0]}, {28'b0, led});
    end

    // UART transmit
    rnd      = $random(seed);
    byte_val = rnd[7:0];
    write_access(SIZE_BYTE, ADDR_UART_OUT, rnd);
    idle_bus();
    repeat (2) @(negedge clk);
    expect_value("uart_tx start bit", 32'h0, {31'b0, uart_tx});
    // read back while the data bits are on the line
    repeat (4 * CLKS_PER_BIT) @(negedge clk);
    read_access({1'b0, SIZE_WORD}, ADDR_UART_OUT, got);
    expect_value("data_out uart out", {24'b0, byte_val}, got);
    idle_bus();
    while (tx_frames.size() == 0) @(negedge clk);
    expect_value("uart_tx byte", {24'b0, byte_val}, {24'b0, tx_frames.pop_front()});
    repeat (CLKS_PER_BIT) @(negedge clk);
    read_access({1'b0, SIZE_WORD}, ADDR_UART_OUT, got);
    expect_value("data_out uart out", IO_IDLE, got);
    idle_bus();
    // a second frame would be decoded by now
    repeat (12 * CLKS_PER_BIT) @(negedge clk);
    expect_value("uart_tx frame count", 32'd0, 32'(tx_frames.size()));

    // UART receive
    rnd      = $random(seed);
    byte_val = rnd[7:0];
    send_serial(byte_val);
    repeat (4) @(posedge clk);
    read_access({1'b0, SIZE_WORD}, ADDR_UART_IN, got);
    expect_value("data_out uart in", {24'b0, byte_val}, got);
    read_access({1'b0, SIZE_WORD}, ADDR_UART_IN, got);
    expect_value("data_out uart in", IO_IDLE, got);
    idle_bus();

    // let the comparator drain
    repeat (2) @(posedge clk);
    report_counts();
    if (value_errors == 0 && line_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
